//--- verilog/kr580_pkg.sv
`default_nettype none

package kr580_pkg;

    // Opcode fields
    localparam int OP_SRC  = 0;         // Bits 2:0, source register
    localparam int OP_DST  = 3;         // Bits 5:3, target, ALU op or condition
    localparam int OP_PAIR = 4;         // Bits 5:4, register pair

    // ALU operations, same order as opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR,  ALU_CP
    } alu_op_t;

    // Flag bits in F
    localparam int FLAG_C = 0;
    localparam int FLAG_P = 2;          // Parity or overflow
    localparam int FLAG_A = 4;          // Half carry
    localparam int FLAG_Z = 6;
    localparam int FLAG_S = 7;

    // Register codes
    localparam logic [2:0] REG_B = 3'd0;
    localparam logic [2:0] REG_C = 3'd1;
    localparam logic [2:0] REG_D = 3'd2;
    localparam logic [2:0] REG_E = 3'd3;
    localparam logic [2:0] REG_H = 3'd4;
    localparam logic [2:0] REG_L = 3'd5;
    localparam logic [2:0] REG_M = 3'd6;    // Memory at HL, F on reads
    localparam logic [2:0] REG_A = 3'd7;

    // Pair codes
    localparam logic [1:0] PAIR_BC = 2'd0;
    localparam logic [1:0] PAIR_DE = 2'd1;
    localparam logic [1:0] PAIR_HL = 2'd2;
    localparam logic [1:0] PAIR_SP = 2'd3;

    // JP cc conditions
    localparam logic [2:0] COND_NZ = 3'd0;
    localparam logic [2:0] COND_Z  = 3'd1;
    localparam logic [2:0] COND_NC = 3'd2;
    localparam logic [2:0] COND_C  = 3'd3;
    localparam logic [2:0] COND_PO = 3'd4;
    localparam logic [2:0] COND_PE = 3'd5;
    localparam logic [2:0] COND_P  = 3'd6;
    localparam logic [2:0] COND_M  = 3'd7;

    // Reset values
    localparam logic [ 7:0] F_RESET  = 8'h40;   // Z only
    localparam logic [15:0] PC_RESET = 16'h0000;

endpackage

`default_nettype wire

//--- verilog/kr580_alu.sv
`timescale 1ns/1ps
`default_nettype none

module kr580_alu (
    input  wire kr580_pkg::alu_op_t op_i,
    input  wire  [7:0]              a_i,
    input  wire  [7:0]              b_i,
    input  wire                     carry_i,    // C from F
    output logic [7:0]              result_o,
    output logic [7:0]              flags_o
);

    logic       sub;        // SUB, SBC and CP
    logic       is_logic;
    logic       cin;
    logic [8:0] sum;        // Bit 8 is carry or borrow
    logic [4:0] half;
    logic       ovf;

    assign sub      = op_i inside {kr580_pkg::ALU_SUB, kr580_pkg::ALU_SBC, kr580_pkg::ALU_CP};
    assign is_logic = op_i inside {kr580_pkg::ALU_AND, kr580_pkg::ALU_XOR,
                                   kr580_pkg::ALU_OR};

    // Only the with-carry forms take C in
    assign cin = (op_i == kr580_pkg::ALU_ADC || op_i == kr580_pkg::ALU_SBC) ? carry_i : 1'b0;

    // Adder and subtractor
    always_comb begin
        if (sub) begin
            sum  = {1'b0, a_i} - {1'b0, b_i} - {8'h00, cin};
            half = {1'b0, a_i[3:0]} - {1'b0, b_i[3:0]} - {4'h0, cin};
            ovf  = (a_i[7] != b_i[7]) && (a_i[7] != sum[7]);
        end else begin
            sum  = {1'b0, a_i} + {1'b0, b_i} + {8'h00, cin};
            half = {1'b0, a_i[3:0]} + {1'b0, b_i[3:0]} + {4'h0, cin};
            ovf  = (a_i[7] == b_i[7]) && (a_i[7] != sum[7]);
        end
    end

    always_comb begin
        case (op_i)
            kr580_pkg::ALU_AND: result_o = a_i & b_i;
            kr580_pkg::ALU_XOR: result_o = a_i ^ b_i;
            kr580_pkg::ALU_OR:  result_o = a_i | b_i;
            default:            result_o = sum[7:0];    // Arithmetic and compare
        endcase
    end

    // --------------------
    // Flag byte

    always_comb begin
        flags_o                    = 8'h02;             // Bit 1 always set
        flags_o[kr580_pkg::FLAG_S] = result_o[7];
        flags_o[kr580_pkg::FLAG_Z] = (result_o == 8'h00);
        flags_o[kr580_pkg::FLAG_A] = !is_logic && half[4];
        flags_o[kr580_pkg::FLAG_C] = !is_logic && sum[8];
        // Even parity for logic and CP, overflow otherwise
        if (is_logic || op_i == kr580_pkg::ALU_CP) begin
            flags_o[kr580_pkg::FLAG_P] = ~^result_o;
        end else begin
            flags_o[kr580_pkg::FLAG_P] = ovf;
        end
    end

endmodule

`default_nettype wire

//--- verilog/kr580_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module kr580_regfile (
    input  wire         pin_clk,
    input  wire         rst_n_i,
    input  wire  [ 2:0] rd_sel_i,       // Code 6 reads F
    input  wire  [ 1:0] rd_pair_i,
    output logic [ 7:0] rd_byte_o,
    output logic [15:0] rd_word_o,
    output logic [ 7:0] a_o,
    output logic [ 7:0] f_o,
    output logic [15:0] hl_o,
    input  wire         wr_byte_i,
    input  wire  [ 2:0] wr_code_i,
    input  wire         wr_pair_i,      // Wins over wr_byte_i
    input  wire  [ 1:0] wr_pair_sel_i,
    input  wire  [15:0] wr_data_i,      // Byte writes use the low half
    input  wire         f_we_i,
    input  wire  [ 7:0] f_data_i
);

    logic [ 7:0] b, c, d, e, h, l, a, f;
    logic [15:0] sp;

    always_ff @(posedge pin_clk) begin
        if (!rst_n_i) begin
            {b, c, d, e, h, l, a} <= '0;
            f  <= kr580_pkg::F_RESET;
            sp <= 16'h0000;
        end else begin
            if (wr_pair_i) begin
                case (wr_pair_sel_i)
                    kr580_pkg::PAIR_BC: {b, c} <= wr_data_i;
                    kr580_pkg::PAIR_DE: {d, e} <= wr_data_i;
                    kr580_pkg::PAIR_HL: {h, l} <= wr_data_i;
                    kr580_pkg::PAIR_SP: sp     <= wr_data_i;
                endcase
            end else if (wr_byte_i) begin
                case (wr_code_i)
                    kr580_pkg::REG_B: b <= wr_data_i[7:0];
                    kr580_pkg::REG_C: c <= wr_data_i[7:0];
                    kr580_pkg::REG_D: d <= wr_data_i[7:0];
                    kr580_pkg::REG_E: e <= wr_data_i[7:0];
                    kr580_pkg::REG_H: h <= wr_data_i[7:0];
                    kr580_pkg::REG_L: l <= wr_data_i[7:0];
                    kr580_pkg::REG_A: a <= wr_data_i[7:0];
                    default: ;                          // Memory operand
                endcase
            end
            if (f_we_i) begin
                f <= f_data_i;
            end
        end
    end

    // --------------------
    // Read ports

    always_comb begin
        case (rd_sel_i)
            kr580_pkg::REG_B: rd_byte_o = b;
            kr580_pkg::REG_C: rd_byte_o = c;
            kr580_pkg::REG_D: rd_byte_o = d;
            kr580_pkg::REG_E: rd_byte_o = e;
            kr580_pkg::REG_H: rd_byte_o = h;
            kr580_pkg::REG_L: rd_byte_o = l;
            kr580_pkg::REG_M: rd_byte_o = f;
            default:          rd_byte_o = a;
        endcase
        case (rd_pair_i)
            kr580_pkg::PAIR_BC: rd_word_o = {b, c};
            kr580_pkg::PAIR_DE: rd_word_o = {d, e};
            kr580_pkg::PAIR_HL: rd_word_o = {h, l};
            default:            rd_word_o = sp;
        endcase
    end

    assign a_o  = a;
    assign f_o  = f;
    assign hl_o = {h, l};

endmodule

`default_nettype wire

//--- verilog/kr580_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module kr580_sequencer (
    input  wire                pin_clk,
    input  wire                rst_n_i,
    // Memory bus
    input  wire  [ 7:0]        data_i,
    output logic [15:0]        addr_o,
    output logic [ 7:0]        data_o,
    output logic               mem_we_o,
    // Port bus
    output logic [ 7:0]        port_addr_o,
    output logic [ 7:0]        port_data_o,
    input  wire  [ 7:0]        port_data_i,
    output logic               port_we_o,
    // ALU
    output kr580_pkg::alu_op_t alu_op_o,
    output logic [ 7:0]        alu_a_o,
    output logic [ 7:0]        alu_b_o,
    input  wire  [ 7:0]        alu_res_i,
    input  wire  [ 7:0]        alu_flags_i,
    // Register file
    output logic [ 2:0]        rd_sel_o,
    output logic [ 1:0]        rd_pair_o,
    input  wire  [ 7:0]        rd_byte_i,
    input  wire  [15:0]        rd_word_i,
    input  wire  [ 7:0]        a_i,
    input  wire  [ 7:0]        f_i,
    input  wire  [15:0]        hl_i,
    output logic               wr_byte_o,
    output logic [ 2:0]        wr_code_o,
    output logic               wr_pair_o,
    output logic [ 1:0]        wr_pair_sel_o,
    output logic [15:0]        wr_data_o,
    output logic               f_we_o,
    output logic [ 7:0]        f_data_o
);

    logic [ 1:0] t;             // T-state
    logic [15:0] pc;
    logic [15:0] cursor;        // Data address
    logic        alt;           // Drive cursor instead of PC
    logic [ 7:0] op_q;
    logic [ 7:0] opnd_q;        // Immediate or source byte
    logic [ 7:0] op;
    logic [ 2:0] dst;
    logic [ 2:0] src;
    logic        dst_m;
    logic [ 1:0] last_t;        // Final state of this opcode
    logic [ 1:0] imm_n;         // Bytes after the opcode
    logic        last;
    logic        pc_inc;
    logic        alt_d;
    logic        mem_we_d;
    logic        cond_ok;
    logic [ 7:0] byte_d;

    logic        is_halt;
    logic        is_ld_ri;
    logic        is_ld_rr;
    logic        is_alu_r;
    logic        is_alu_i;
    logic        is_alu;
    logic        is_incdec;
    logic        is_ld_pi;
    logic        is_incdec_rr;
    logic        is_st_a;
    logic        is_ld_a;
    logic        is_jp;
    logic        is_out;
    logic        is_in;
    logic        is_abs;

    // --------------------
    // Decode

    assign op     = (t == 2'd0) ? data_i : op_q;    // Opcode is on the bus in T0
    assign dst    = op[kr580_pkg::OP_DST +: 3];
    assign src    = op[kr580_pkg::OP_SRC +: 3];
    assign dst_m  = (dst == kr580_pkg::REG_M);
    assign addr_o = alt ? cursor : pc;

    assign is_halt      = (op == 8'h76);
    assign is_ld_ri     = (op[7:6] == 2'b00) && (op[2:0] == 3'b110);
    assign is_incdec    = (op[7:6] == 2'b00) && (op[2:1] == 2'b10);
    assign is_ld_pi     = (op[7:6] == 2'b00) && (op[3:0] == 4'b0001);
    assign is_incdec_rr = (op[7:6] == 2'b00) && (op[2:0] == 3'b011);
    assign is_st_a      = (op == 8'h32);
    assign is_ld_a      = (op == 8'h3A);
    assign is_ld_rr     = (op[7:6] == 2'b01) && !is_halt;
    assign is_alu_r     = (op[7:6] == 2'b10);
    assign is_alu_i     = (op[7:6] == 2'b11) && (op[2:0] == 3'b110);
    assign is_alu       = is_alu_r || is_alu_i;
    assign is_jp        = (op == 8'hC3) || ((op[7:6] == 2'b11) && (op[2:0] == 3'b010));
    assign is_out       = (op == 8'hD3);
    assign is_in        = (op == 8'hDB);
    assign is_abs       = is_st_a || is_ld_a || is_jp;  // Address bytes go to cursor

    // State count and code bytes, unknown opcodes stay at zero
    always_comb begin
        last_t = 2'd0;
        imm_n  = 2'd0;
        if (is_incdec_rr || is_out) begin
            last_t = 2'd1;
        end
        if (is_ld_ri || is_alu || is_ld_pi || is_in) begin
            last_t = 2'd2;
        end
        if (is_ld_rr || is_incdec || is_abs) begin
            last_t = 2'd3;
        end
        if (is_ld_ri || is_alu_i || is_out || is_in) begin
            imm_n = 2'd1;
        end
        if (is_ld_pi || is_abs) begin
            imm_n = 2'd2;
        end
    end

    assign last   = (t == last_t);
    assign pc_inc = (t == 2'd0) ? !is_halt : (t <= imm_n);   // HALT refetches itself

    always_comb begin
        case (dst)
            kr580_pkg::COND_NZ: cond_ok = !f_i[kr580_pkg::FLAG_Z];
            kr580_pkg::COND_Z:  cond_ok =  f_i[kr580_pkg::FLAG_Z];
            kr580_pkg::COND_NC: cond_ok = !f_i[kr580_pkg::FLAG_C];
            kr580_pkg::COND_C:  cond_ok =  f_i[kr580_pkg::FLAG_C];
            kr580_pkg::COND_PO: cond_ok = !f_i[kr580_pkg::FLAG_P];
            kr580_pkg::COND_PE: cond_ok =  f_i[kr580_pkg::FLAG_P];
            kr580_pkg::COND_P:  cond_ok = !f_i[kr580_pkg::FLAG_S];
            kr580_pkg::COND_M:  cond_ok =  f_i[kr580_pkg::FLAG_S];
        endcase
    end

    // Cursor on the bus for HL reads in T1 and for writes and loads in the last state
    assign alt_d = ((t == 2'd0) && (is_ld_rr || is_alu_r || is_incdec))
                || ((t == 2'd1) && is_ld_ri)
                || ((t == 2'd2) && (is_ld_rr || is_incdec || is_st_a || is_ld_a));

    assign mem_we_d = (((t == 2'd1) && is_ld_ri) || ((t == 2'd2) && (is_ld_rr || is_incdec)))
                      && dst_m || ((t == 2'd2) && is_st_a);

    // --------------------
    // ALU and register file

    assign alu_a_o  = is_incdec ? opnd_q : a_i;
    assign alu_b_o  = is_incdec ? 8'h01 : opnd_q;
    assign alu_op_o = !is_incdec ? kr580_pkg::alu_op_t'(dst)
                    : (op[0] ? kr580_pkg::ALU_SUB : kr580_pkg::ALU_ADD);

    assign rd_sel_o      = is_incdec ? dst : src;
    assign rd_pair_o     = op[kr580_pkg::OP_PAIR +: 2];
    assign wr_pair_sel_o = op[kr580_pkg::OP_PAIR +: 2];

    always_comb begin
        if (is_alu || is_incdec) begin
            byte_d = alu_res_i;
        end else if (is_ld_a) begin
            byte_d = data_i;
        end else if (is_in) begin
            byte_d = port_data_i;
        end else begin
            byte_d = opnd_q;                // LD r,i8 and LD r,r
        end
        if (is_ld_pi) begin
            wr_data_o = {data_i, opnd_q};
        end else if (is_incdec_rr) begin
            wr_data_o = op[3] ? rd_word_i - 16'd1 : rd_word_i + 16'd1;
        end else begin
            wr_data_o = {8'h00, byte_d};
        end
    end

    // Writes land at the edge that closes the instruction
    assign wr_byte_o = last && (((is_ld_ri || is_ld_rr || is_incdec) && !dst_m)
                     || (is_alu && alu_op_o != kr580_pkg::ALU_CP) || is_ld_a || is_in);
    assign wr_code_o = (is_ld_ri || is_ld_rr || is_incdec) ? dst : kr580_pkg::REG_A;
    assign wr_pair_o = last && (is_ld_pi || is_incdec_rr);
    assign f_we_o    = last && (is_alu || is_incdec);
    assign f_data_o  = alu_flags_i;

    // --------------------
    // State

    always_ff @(posedge pin_clk) begin
        if (!rst_n_i) begin
            t         <= 2'd0;
            pc        <= kr580_pkg::PC_RESET;
            cursor    <= 16'h0000;
            alt       <= 1'b0;
            mem_we_o  <= 1'b0;
            port_we_o <= 1'b0;
        end else begin
            t         <= last ? 2'd0 : t + 2'd1;
            alt       <= alt_d;
            mem_we_o  <= mem_we_d;
            port_we_o <= is_out && (t == 2'd1);
            if (is_jp && last && (op[0] || cond_ok)) begin
                pc <= cursor;               // JP nn has bit 0 set
            end else if (pc_inc) begin
                pc <= pc + 16'd1;
            end
            if (t == 2'd0) begin
                cursor <= hl_i;
            end else if (is_abs && (t == 2'd1)) begin
                cursor[7:0] <= data_i;
            end else if (is_abs && (t == 2'd2)) begin
                cursor[15:8] <= data_i;
            end
        end
    end

    always_ff @(posedge pin_clk) begin
        if (t == 2'd0) begin
            op_q <= data_i;
        end
        if (t == 2'd1) begin
            opnd_q <= (!alt || rd_sel_o == kr580_pkg::REG_M) ? data_i : rd_byte_i;
        end
        if (mem_we_d) begin
            if (is_ld_ri) begin
                data_o <= data_i;
            end else if (is_ld_rr) begin
                data_o <= opnd_q;
            end else if (is_incdec) begin
                data_o <= alu_res_i;
            end else begin
                data_o <= a_i;
            end
        end
        if ((is_out || is_in) && (t == 2'd1)) begin
            port_addr_o <= data_i;
        end
        if (is_out && (t == 2'd1)) begin
            port_data_o <= a_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/kr580_core.sv
`timescale 1ns/1ps
`default_nettype none

module kr580_core (
    input  wire         pin_clk,
    input  wire         rst_n_i,
    // Memory bus
    input  wire  [ 7:0] data_i,
    output wire  [15:0] addr_o,
    output wire  [ 7:0] data_o,
    output wire         mem_we_o,
    // Port bus
    output wire  [ 7:0] port_addr_o,
    output wire  [ 7:0] port_data_o,
    input  wire  [ 7:0] port_data_i,
    output wire         port_we_o
);

    kr580_pkg::alu_op_t alu_op;
    logic [ 7:0] alu_a;
    logic [ 7:0] alu_b;
    logic [ 7:0] alu_res;
    logic [ 7:0] alu_flags;
    logic [ 2:0] rd_sel;
    logic [ 1:0] rd_pair;
    logic [ 7:0] rd_byte;
    logic [15:0] rd_word;
    logic [ 7:0] reg_a;
    logic [ 7:0] reg_f;
    logic [15:0] reg_hl;
    logic        wr_byte;
    logic [ 2:0] wr_code;
    logic        wr_pair;
    logic [ 1:0] wr_pair_sel;
    logic [15:0] wr_data;
    logic        f_we;
    logic [ 7:0] f_data;

    kr580_sequencer seq0 (
        .pin_clk       (pin_clk),
        .rst_n_i       (rst_n_i),
        .data_i        (data_i),
        .addr_o        (addr_o),
        .data_o        (data_o),
        .mem_we_o      (mem_we_o),
        .port_addr_o   (port_addr_o),
        .port_data_o   (port_data_o),
        .port_data_i   (port_data_i),
        .port_we_o     (port_we_o),
        .alu_op_o      (alu_op),
        .alu_a_o       (alu_a),
        .alu_b_o       (alu_b),
        .alu_res_i     (alu_res),
        .alu_flags_i   (alu_flags),
        .rd_sel_o      (rd_sel),
        .rd_pair_o     (rd_pair),
        .rd_byte_i     (rd_byte),
        .rd_word_i     (rd_word),
        .a_i           (reg_a),
        .f_i           (reg_f),
        .hl_i          (reg_hl),
        .wr_byte_o     (wr_byte),
        .wr_code_o     (wr_code),
        .wr_pair_o     (wr_pair),
        .wr_pair_sel_o (wr_pair_sel),
        .wr_data_o     (wr_data),
        .f_we_o        (f_we),
        .f_data_o      (f_data)
    );

    kr580_alu alu0 (
        .op_i     (alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .carry_i  (reg_f[kr580_pkg::FLAG_C]),
        .result_o (alu_res),
        .flags_o  (alu_flags)
    );

    kr580_regfile rf0 (
        .pin_clk       (pin_clk),
        .rst_n_i       (rst_n_i),
        .rd_sel_i      (rd_sel),
        .rd_pair_i     (rd_pair),
        .rd_byte_o     (rd_byte),
        .rd_word_o     (rd_word),
        .a_o           (reg_a),
        .f_o           (reg_f),
        .hl_o          (reg_hl),
        .wr_byte_i     (wr_byte),
        .wr_code_i     (wr_code),
        .wr_pair_i     (wr_pair),
        .wr_pair_sel_i (wr_pair_sel),
        .wr_data_i     (wr_data),
        .f_we_i        (f_we),
        .f_data_i      (f_data)
    );

endmodule

`default_nettype wire

//--- bench/kr580_assert.sv
`timescale 1ns/1ps
`default_nettype none

module kr580_assert (
    input wire pin_clk,
    input wire rst_n_i,
    input wire mem_we_o,
    input wire port_we_o
);

    // --------------------
    // Reset behavior

    // Checked one edge later, so the cycle after release is covered too
    property strobes_quiet_after_reset;
        @(posedge pin_clk) !rst_n_i |=> (!mem_we_o && !port_we_o);
    endproperty

    quiet_after_reset: assert property (strobes_quiet_after_reset)
        else $error("write strobe seen during or right after reset");

    // --------------------
    // Strobe shape

    property port_we_single_cycle;
        @(posedge pin_clk) disable iff (!rst_n_i)
            port_we_o |=> !port_we_o;
    endproperty

    single_port_pulse: assert property (port_we_single_cycle)
        else $error("port_we_o held high for two cycles");

    property strobes_exclusive;
        @(posedge pin_clk) disable iff (!rst_n_i)
            !(mem_we_o && port_we_o);
    endproperty

    no_double_strobe: assert property (strobes_exclusive)
        else $error("mem_we_o and port_we_o high together");

endmodule

`default_nettype wire

//--- bench/kr580_tb.sv
`timescale 1ns/1ps
`default_nettype none

module kr580_tb;

    localparam logic [15:0] DATA_ADDR  = 16'h8000;   // Random bytes live here
    localparam logic [15:0] STORE_ADDR = 16'h9000;
    localparam logic [15:0] HL_BASE    = 16'h9100;

    logic        pin_clk;
    logic        rst_n_i;
    logic [ 7:0] data_i;
    logic [15:0] addr_o;
    logic [ 7:0] data_o;
    logic        mem_we_o;
    logic [ 7:0] port_addr_o;
    logic [ 7:0] port_data_o;
    logic [ 7:0] port_data_i;
    logic        port_we_o;

    logic [ 7:0] image [0:65535];       // Program and data, written before reset
    logic [ 7:0] wmem  [0:65535];       // Bytes stored by the core
    bit          wvalid [0:65535];
    logic [24:0] exp_q [$];             // {memory write, address, data}
    logic [24:0] exp_e;
    int          exp_idx;
    logic        port_we_q;
    logic [31:0] lfsr;
    logic [15:0] pc_w;                  // Next program byte
    logic [15:0] halt_addr;
    logic [15:0] m_hl;
    logic [ 7:0] m_a;
    logic        m_c;
    logic        m_z;
    logic [ 7:0] rb;
    logic [ 7:0] rv;
    int          value_errors;
    int          other_errors;
    int          flow_errors;
    bit          ok;

    kr580_core dut0 (
        .pin_clk     (pin_clk),
        .rst_n_i     (rst_n_i),
        .data_i      (data_i),
        .addr_o      (addr_o),
        .data_o      (data_o),
        .mem_we_o    (mem_we_o),
        .port_addr_o (port_addr_o),
        .port_data_o (port_data_o),
        .port_data_i (port_data_i),
        .port_we_o   (port_we_o)
    );

    bind kr580_core kr580_assert chk0 (
        .pin_clk   (pin_clk),
        .rst_n_i   (rst_n_i),
        .mem_we_o  (mem_we_o),
        .port_we_o (port_we_o)
    );

    initial begin
        pin_clk = 1'b0;
        forever #2 pin_clk = ~pin_clk;
    end

    // --------------------
    // Memory and port models

    assign data_i      = wvalid[addr_o] ? wmem[addr_o] : image[addr_o];
    assign port_data_i = port_addr_o ^ 8'h5A;

    always @(posedge pin_clk) begin
        if (mem_we_o) begin
            wmem[addr_o]   <= data_o;
            wvalid[addr_o] <= 1'b1;
        end
    end

    // --------------------
    // Write checker

    always @(negedge pin_clk) begin
        if (rst_n_i) begin
            if (port_we_o || mem_we_o) begin
                if (exp_idx >= exp_q.size()) begin
                    $display("Write strobe seen after the expected list ran out");
                    other_errors++;
                end else begin
                    exp_e = exp_q[exp_idx];
                    exp_idx++;
                    assert (exp_e[24] == mem_we_o) else begin
                        $display("Write %0d went to the wrong bus", exp_idx);
                        other_errors++;
                    end
                    if (mem_we_o) begin
                        assert (addr_o == exp_e[23:8]) else begin
                            $display("Error addr_o: got %h, expected %h", addr_o, exp_e[23:8]);
                            value_errors++;
                        end
                        assert (data_o == exp_e[7:0]) else begin
                            $display("Error data_o: got %h, expected %h", data_o, exp_e[7:0]);
                            value_errors++;
                        end
                    end else begin
                        assert (port_addr_o == exp_e[15:8]) else begin
                            $display("Error port_addr_o: got %h, expected %h",
                                     port_addr_o, exp_e[15:8]);
                            value_errors++;
                        end
                        assert (port_data_o == exp_e[7:0]) else begin
                            $display("Error port_data_o: got %h, expected %h",
                                     port_data_o, exp_e[7:0]);
                            value_errors++;
                        end
                    end
                end
            end
            assert (!(port_we_o && mem_we_o)) else begin
                $display("Memory and port strobes fired in the same cycle");
                other_errors++;
            end
            assert (!(port_we_o && port_we_q)) else begin
                $display("Port strobe stayed high for two cycles");
                other_errors++;
            end
        end
        port_we_q <= port_we_o;
    end

    // --------------------
    // Stimulus helpers

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b    = {b[6:0], lfsr[0]};     // One step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Returns {carry, result} for one ALU operation code
    function automatic logic [8:0] alu_ref(input logic [2:0] op, input logic [7:0] a,
                                           input logic [7:0] b, input logic cin);
        logic [8:0] r;
        case (op)
            3'd0:    r = {1'b0, a} + {1'b0, b};
            3'd1:    r = {1'b0, a} + {1'b0, b} + {8'h00, cin};
            3'd3:    r = {1'b0, a} - {1'b0, b} - {8'h00, cin};
            3'd4:    r = {1'b0, a & b};
            3'd5:    r = {1'b0, a ^ b};
            3'd6:    r = {1'b0, a | b};
            default: r = {1'b0, a} - {1'b0, b};   // SUB and CP
        endcase
        return r;
    endfunction

    task automatic emit(input logic [7:0] b);
        image[pc_w] = b;
        pc_w        = pc_w + 16'd1;
    endtask

    task automatic emit_word(input logic [15:0] w);
        emit(w[7:0]);
        emit(w[15:8]);
    endtask

    task automatic ld_a(input logic [7:0] v);
        emit(8'h3E);
        emit(v);
        m_a = v;
    endtask

    task automatic alu_step(input logic [2:0] op, input logic [7:0] v);
        logic [8:0] r;
        r = alu_ref(op, m_a, v, m_c);
        m_c = r[8];
        m_z = (r[7:0] == 8'h00);
        if (op != 3'd7) begin
            m_a = r[7:0];                   // CP keeps A
        end
    endtask

    task automatic alu_imm(input logic [2:0] op, input logic [7:0] v);
        emit({2'b11, op, 3'b110});
        emit(v);
        alu_step(op, v);
    endtask

    task automatic out_a(input logic [7:0] port);
        emit(8'hD3);
        emit(port);
        exp_q.push_back({1'b0, 8'h00, port, m_a});
    endtask

    // JP cc over two OUT paths, then both meet again
    task automatic jp_block(input logic [7:0] opc, input bit take, input logic [7:0] port,
                            input logic [7:0] fall_v, input logic [7:0] take_v);
        logic [15:0] join_addr;
        join_addr = pc_w + 16'd14;
        emit(opc);
        emit_word(pc_w + 16'd9);            // Taken path after 10 bytes from opcode
        emit(8'h3E);
        emit(fall_v);
        emit(8'hD3);
        emit(port);
        emit(8'hC3);
        emit_word(join_addr);
        emit(8'h3E);
        emit(take_v);
        emit(8'hD3);
        emit(port);
        m_a = take ? take_v : fall_v;
        exp_q.push_back({1'b0, 8'h00, port, m_a});
    endtask

    task automatic build_program();
        for (int i = 0; i < 65536; i++) begin
            image[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'hC7;
        end
        for (int k = 0; k < 4; k++) begin
            next_byte(rv);
            image[DATA_ADDR + k[15:0]] = rv;
        end
        pc_w = 16'h0000;
        m_c  = 1'b0;                        // F after reset has C clear
        m_z  = 1'b1;
        // ALU chain
        next_byte(rb);
        emit(8'h06);
        emit(rb);
        next_byte(rv);
        ld_a(rv);
        emit(8'h80);                        // ADD A,B
        alu_step(3'd0, rb);
        out_a(8'h01);
        for (int op = 1; op < 8; op++) begin
            next_byte(rv);
            alu_imm(op[2:0], rv);
            out_a(8'h01 + op[7:0]);
        end
        // Branches on zero, then on carry
        ld_a(8'h3C);
        alu_imm(3'd2, 8'h3C);
        jp_block(8'hC2, !m_z, 8'h10, 8'h11, 8'h12);
        jp_block(8'hCA, m_z, 8'h11, 8'h21, 8'h22);
        ld_a(8'h10);
        alu_imm(3'd2, 8'h20);
        jp_block(8'hDA, m_c, 8'h12, 8'h31, 8'h32);
        jp_block(8'hD2, !m_c, 8'h13, 8'h41, 8'h42);
        // Port read
        emit(8'hDB);
        emit(8'h37);
        m_a = 8'h37 ^ 8'h5A;
        out_a(8'h40);
        // Memory and pairs
        next_byte(rv);
        ld_a(rv);
        emit(8'h32);
        emit_word(STORE_ADDR);
        exp_q.push_back({1'b1, STORE_ADDR, m_a});
        emit(8'h21);
        emit_word(HL_BASE);
        emit(8'h23);
        emit(8'h23);
        emit(8'h2B);
        m_hl = HL_BASE + 16'd1;
        next_byte(rv);
        emit(8'h36);
        emit(rv);
        exp_q.push_back({1'b1, m_hl, rv});
        emit(8'h34);                        // INC M
        exp_q.push_back({1'b1, m_hl, rv + 8'd1});
        emit(8'h3A);
        emit_word(DATA_ADDR);
        m_a = image[DATA_ADDR];
        out_a(8'h50);
        emit(8'h3A);
        emit_word(m_hl);
        m_a = rv + 8'd1;
        out_a(8'h51);
        halt_addr = pc_w;
        emit(8'h76);
    endtask

    // --------------------
    // Waits and run

    task automatic wait_writes_done(output bit done);
        done = 1'b0;
        for (int n = 0; n < 2000 && !done; n++) begin
            @(posedge pin_clk);
            done = (exp_idx == exp_q.size());
        end
        if (!done) begin
            $display("Timed out before all expected writes appeared");
        end
    endtask

    task automatic wait_halt_fetch(output bit done);
        done = 1'b0;
        for (int n = 0; n < 100 && !done; n++) begin
            @(negedge pin_clk);
            done = (addr_o == halt_addr);
        end
        if (!done) begin
            $display("Timed out waiting for the core to reach HALT");
        end
    endtask

    task automatic check_halt_idle();
        for (int n = 0; n < 20; n++) begin
            @(negedge pin_clk);
            if (addr_o != halt_addr) begin
                $display("Error addr_o: got %h, expected %h", addr_o, halt_addr);
                flow_errors++;
            end
            if (mem_we_o || port_we_o) begin
                $display("Write strobe seen while halted");
                flow_errors++;
            end
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        lfsr    = 32'h403827a8;
        exp_idx = 0;
        build_program();
        repeat (10) @(posedge pin_clk);
        #1 rst_n_i = 1'b1;
        @(negedge pin_clk);
        if (addr_o != 16'h0000) begin
            $display("Error addr_o: got %h, expected %h", addr_o, 16'h0000);
            flow_errors++;
        end
        if (mem_we_o || port_we_o) begin
            $display("Write strobe seen in the first cycle after reset");
            flow_errors++;
        end
        wait_writes_done(ok);
        if (ok) begin
            wait_halt_fetch(ok);
        end
        if (ok) begin
            check_halt_idle();
        end
        $display("Errors: %0d value, %0d other, %0d flow",
                 value_errors, other_errors, flow_errors);
        if (ok && value_errors == 0 && other_errors == 0 && flow_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- kr580_core.f
verilog/kr580_pkg.sv
verilog/kr580_alu.sv
verilog/kr580_regfile.sv
verilog/kr580_sequencer.sv
verilog/kr580_core.sv
bench/kr580_assert.sv
bench/kr580_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the kr580 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module kr580_tb \
    -f kr580_core.f -o kr580_sim

out=$(./obj_dir/kr580_sim)
echo "$out"

if grep -qx "Test passed" <<< "$out"; then
    exit 0
else
    exit 1
fi
